/* run_sim.sh */
#!/bin/sh
# build and run the scope_ctl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f scope_ctl.f --top-module scope_ctl_tb \
	-Mdir obj_dir -o scope_ctl_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/scope_ctl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

/* scope_ctl.f */
+incdir+source
source/cmd_pkg.sv
source/periph_pkg.sv
source/cmd_frame_rx.sv
source/spi_sequencer.sv
source/cmd_exec.sv
source/resp_tx.sv
source/scope_ctl_top.sv
test/scope_ctl_tb.sv

/* source/cmd_exec.sv */
`timescale 1ns/1ps
`include "scope_ctl_defs.svh"

module cmd_exec (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_frame_valid,
	input  cmd_pkg::cmd_frame_t   i_frame,
	output logic                  o_frame_take,
	input  logic                  i_resp_free,
	output logic                  o_resp_load,
	output cmd_pkg::resp_word_t   o_resp,
	output cmd_pkg::byte_t        o_spi_tx,
	output logic                  o_spi_txdv,
	input  logic                  i_spi_txready,
	input  logic                  i_spi_rxdv,
	input  cmd_pkg::byte_t        i_spi_rx,
	output logic [7:0]            o_spi_cs,
	output periph_pkg::trig_cfg_t o_trig,
	output periph_pkg::acq_cfg_t  o_acq,
	output logic [7:0]            o_boardout,
	output logic [1:0]            o_spi_mode,
	output logic                  o_spi_reset_n,
	output logic [2:0]            o_miso_sel,
	input  logic [7:0]            i_acqstate,
	input  logic [31:0]           i_eventcounter,
	input  logic [7:0]            i_boardin
);

	cmd_pkg::opcode_e      op;
	periph_pkg::spi_req_t  spi_req;
	periph_pkg::thresh_t   lo_th;
	periph_pkg::thresh_t   hi_th;
	logic                  spi_start;
	logic                  spi_done;
	logic                  spi_busy;
	cmd_pkg::byte_t        rd_hi;
	cmd_pkg::byte_t        rd_lo;
	logic                  act;    // frame accepted this cycle
	logic                  is_reg; // answered without spi
	cmd_pkg::resp_word_t   rsp_val;
	cmd_pkg::resp_word_t   rd_val;
	logic [7:0]            acqstate_q;
	logic [7:0]            boardin_q;
	logic [31:0]           eventcounter_q;

	assign op  = cmd_pkg::opcode_e'(i_frame.opcode);
	assign act = i_frame_valid && i_resp_free && !spi_busy && !o_frame_take && !o_resp_load;

	assign lo_th = periph_pkg::thresh_t'(((12'(i_frame.a1) - 12'(i_frame.a2)
		- 12'(`THRESH_CENTER)) << 4) + 12'(`THRESH_ROUND));
	assign hi_th = periph_pkg::thresh_t'(((12'(i_frame.a1) + 12'(i_frame.a2)
		- 12'(`THRESH_CENTER)) << 4) + 12'(`THRESH_ROUND));

	assign spi_req.chip     = i_frame.a1[2:0];
	assign spi_req.tx       = {i_frame.a5, i_frame.a4, i_frame.a3, i_frame.a2};
	assign spi_req.cnt_code = (i_frame.a7 == 8'd2) ? 2'd1 :
	                          (i_frame.a7 == 8'd4) ? 2'd3 : 2'd2; // anything else is 3 bytes

	always_comb begin
		case (i_frame.a1)
			8'd0:    rd_val = 32'(`SCOPE_VERSION);
			8'd1:    rd_val = {24'd0, boardin_q};
			8'd2:    rd_val = {24'd0, acqstate_q};
			8'd3:    rd_val = eventcounter_q;
			8'd4:    rd_val = {27'd0, o_acq.downsample};
			8'd5:    rd_val = {31'd0, o_acq.highres};
			8'd6:    rd_val = {20'd0, o_trig.upper};
			8'd7:    rd_val = {24'd0, o_acq.merging};
			default: rd_val = '0;
		endcase
	end

	always_comb begin
		is_reg  = 1'b1;
		rsp_val = '0;
		case (op)
			cmd_pkg::TRIG_SET:  rsp_val = 32'd8;
			cmd_pkg::ACQ_SET:   rsp_val = 32'd9;
			cmd_pkg::BOARD_OUT: rsp_val = {24'd0, o_boardout}; // value before the write
			cmd_pkg::SPI_MODE:  rsp_val = {24'd0, i_frame.a1};
			cmd_pkg::READ_REG:  rsp_val = rd_val;
			default:            is_reg  = 1'b0; // spi or unknown
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_frame_take  <= 1'b0;
			o_resp_load   <= 1'b0;
			spi_start     <= 1'b0;
			spi_busy      <= 1'b0;
			o_trig        <= '0;
			o_acq         <= '0;
			o_boardout    <= '0;
			o_spi_mode    <= '0;
			o_spi_reset_n <= 1'b1;
			o_miso_sel    <= '0;
		end else begin
			o_frame_take  <= act; // unknown opcodes are dropped here too
			o_resp_load   <= (act && is_reg) || spi_done;
			spi_start     <= act && (op == cmd_pkg::SPI_XFER);
			o_spi_reset_n <= !(act && (op == cmd_pkg::SPI_MODE));
			if (act && (op == cmd_pkg::SPI_XFER)) spi_busy <= 1'b1;
			else if (spi_done) spi_busy <= 1'b0;
			if (act) begin
				case (op)
					cmd_pkg::TRIG_SET: begin
						o_trig.lower <= lo_th;
						o_trig.upper <= hi_th;
						o_trig.tot   <= i_frame.a3;
						o_trig.chan  <= i_frame.a4[0];
					end
					cmd_pkg::ACQ_SET: begin
						o_acq.downsample <= i_frame.a1[4:0];
						o_acq.highres    <= i_frame.a2[0];
						o_acq.merging    <= i_frame.a3;
					end
					cmd_pkg::BOARD_OUT: o_boardout[i_frame.a1[2:0]] <= i_frame.a2[0];
					cmd_pkg::SPI_MODE:  o_spi_mode <= i_frame.a1[1:0];
					cmd_pkg::SPI_XFER:  o_miso_sel <= i_frame.a1[2:0];
					default: ;
				endcase
			end
		end
	end

	// input sync and response word
	always_ff @(posedge clk) begin
		acqstate_q     <= i_acqstate;
		boardin_q      <= i_boardin;
		eventcounter_q <= i_eventcounter;
		if (spi_done) o_resp <= {16'd0, rd_hi, rd_lo};
		else if (act) o_resp <= rsp_val;
	end

	spi_sequencer u_spi (
		.clk           (clk),
		.rstn          (rstn),
		.i_start       (spi_start),
		.i_req         (spi_req),
		.o_done        (spi_done),
		.o_rd_hi       (rd_hi),
		.o_rd_lo       (rd_lo),
		.o_spi_tx      (o_spi_tx),
		.o_spi_txdv    (o_spi_txdv),
		.i_spi_txready (i_spi_txready),
		.i_spi_rxdv    (i_spi_rxdv),
		.i_spi_rx      (i_spi_rx),
		.o_spi_cs      (o_spi_cs)
	);

endmodule

/* source/cmd_frame_rx.sv */
`timescale 1ns/1ps
`include "scope_ctl_defs.svh"

module cmd_frame_rx (
	input  logic                clk,
	input  logic                rstn,
	input  logic                i_tvalid,
	input  cmd_pkg::byte_t      i_tdata,
	output logic                o_tready,
	output logic                o_frame_valid,
	output cmd_pkg::cmd_frame_t o_frame,
	input  logic                i_frame_take
);

	logic [2:0]          byte_cnt;
	logic                asm_full; // assembly buffer holds 8 bytes
	logic                accept;
	logic                move;     // assembly -> holding register
	cmd_pkg::cmd_frame_t asm_q;

	assign o_tready = !asm_full;
	assign accept   = i_tvalid && o_tready;
	assign move     = asm_full && (!o_frame_valid || i_frame_take);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= '0;
			asm_full      <= 1'b0;
			o_frame_valid <= 1'b0;
		end else begin
			if (accept) begin
				if (byte_cnt == 3'(`CMD_BYTES - 1)) begin
					byte_cnt <= '0;
					asm_full <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 3'd1;
				end
			end
			if (move) begin
				asm_full      <= 1'b0;
				o_frame_valid <= 1'b1; // take and refill on the same edge
			end else if (i_frame_take) begin
				o_frame_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) asm_q <= cmd_pkg::cmd_frame_t'({asm_q[55:0], i_tdata}); // shift in at lsb
		if (move) o_frame <= asm_q;
	end

endmodule

/* source/cmd_pkg.sv */
package cmd_pkg;

	// one byte of the host stream
	typedef logic [7:0] byte_t;

	// opcodes handled by the executor
	typedef enum logic [7:0] {
		SPI_XFER  = 8'd3,
		SPI_MODE  = 8'd4,
		TRIG_SET  = 8'd8,
		ACQ_SET   = 8'd9,
		BOARD_OUT = 8'd10,
		READ_REG  = 8'd14
	} opcode_e;

	// first byte on the wire lands in opcode
	typedef struct packed {
		byte_t opcode;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		byte_t a4;
		byte_t a5;
		byte_t a6;
		byte_t a7;
	} cmd_frame_t;

	// single-beat reply to the host
	typedef logic [31:0] resp_word_t;

endpackage

/* source/periph_pkg.sv */
package periph_pkg;

	// signed adc threshold code
	typedef logic signed [11:0] thresh_t;

	// settings for the triggerer
	typedef struct packed {
		thresh_t    lower;
		thresh_t    upper;
		logic [7:0] tot;  // time over threshold
		logic       chan; // trigger channel
	} trig_cfg_t;

	// acquisition settings
	typedef struct packed {
		logic [4:0] downsample;
		logic       highres;
		logic [7:0] merging; // downsample merging
	} acq_cfg_t;

	// one spi transaction, tx[0] goes out first
	typedef struct packed {
		logic [2:0]      chip;
		logic [3:0][7:0] tx;
		logic [1:0]      cnt_code; // bytes minus one
	} spi_req_t;

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_SETUP,
		SPI_SEND,
		SPI_WAIT,
		SPI_HOLD
	} spi_state_e;

endpackage

/* source/resp_tx.sv */
`timescale 1ns/1ps

module resp_tx (
	input  logic                clk,
	input  logic                rstn,
	input  logic                i_load,
	input  cmd_pkg::resp_word_t i_word,
	output logic                o_free,
	output logic                o_tvalid,
	output cmd_pkg::resp_word_t o_tdata,
	output logic [3:0]          o_tkeep,
	output logic                o_tlast,
	input  logic                i_tready
);

	logic                tx_valid;
	cmd_pkg::resp_word_t word_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tx_valid <= 1'b0;
		end else if (i_load) begin
			tx_valid <= 1'b1;
		end else if (i_tready) begin
			tx_valid <= 1'b0; // accepted by the host side
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) word_q <= i_word;
	end

	assign o_free   = !tx_valid;
	assign o_tvalid = tx_valid;
	assign o_tdata  = word_q;
	assign o_tkeep  = {4{tx_valid}}; // always a full single beat
	assign o_tlast  = tx_valid;

endmodule

/* source/scope_ctl_defs.svh */
`ifndef SCOPE_CTL_DEFS_SVH
`define SCOPE_CTL_DEFS_SVH

// firmware version reported by read register 0
`define SCOPE_VERSION 25

// bytes in one host command frame
`define CMD_BYTES 8

// chip select low to first byte, in clocks
`define SPI_CS_SETUP 11

// last read byte to chip select high, in clocks
`define SPI_CS_HOLD 36

// mid-scale adc code
`define THRESH_CENTER 128

// rounding offset added after the x16 scaling
`define THRESH_ROUND 8

`endif

/* source/scope_ctl_top.sv */
`timescale 1ns/1ps

module scope_ctl_top (
	input  logic                  clk,
	input  logic                  rstn,
	// host command stream
	input  logic                  i_tvalid,
	input  cmd_pkg::byte_t        i_tdata,
	output logic                  o_in_ready,
	// host response stream
	input  logic                  i_out_ready,
	output logic                  o_tvalid,
	output cmd_pkg::resp_word_t   o_tdata,
	output logic [3:0]            o_tkeep,
	output logic                  o_tlast,
	// spi engine
	output cmd_pkg::byte_t        o_spi_tx,
	output logic                  o_spi_txdv,
	input  logic                  i_spi_txready,
	input  logic                  i_spi_rxdv,
	input  cmd_pkg::byte_t        i_spi_rx,
	output logic [7:0]            o_spi_cs,
	output logic [2:0]            o_miso_sel,
	output logic [1:0]            o_spi_mode,
	output logic                  o_spi_reset_n,
	// settings to triggerer and board
	output periph_pkg::trig_cfg_t o_trig,
	output periph_pkg::acq_cfg_t  o_acq,
	output logic [7:0]            o_boardout,
	input  logic [7:0]            i_acqstate,
	input  logic [31:0]           i_eventcounter,
	input  logic [7:0]            i_boardin
);

	logic                frame_valid;
	logic                frame_take;
	cmd_pkg::cmd_frame_t frame;
	logic                resp_free;
	logic                resp_load;
	cmd_pkg::resp_word_t resp;

	cmd_frame_rx u_rx (
		.clk           (clk),
		.rstn          (rstn),
		.i_tvalid      (i_tvalid),
		.i_tdata       (i_tdata),
		.o_tready      (o_in_ready),
		.o_frame_valid (frame_valid),
		.o_frame       (frame),
		.i_frame_take  (frame_take)
	);

	cmd_exec u_exec (
		.clk            (clk),
		.rstn           (rstn),
		.i_frame_valid  (frame_valid),
		.i_frame        (frame),
		.o_frame_take   (frame_take),
		.i_resp_free    (resp_free),
		.o_resp_load    (resp_load),
		.o_resp         (resp),
		.o_spi_tx       (o_spi_tx),
		.o_spi_txdv     (o_spi_txdv),
		.i_spi_txready  (i_spi_txready),
		.i_spi_rxdv     (i_spi_rxdv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_cs       (o_spi_cs),
		.o_trig         (o_trig),
		.o_acq          (o_acq),
		.o_boardout     (o_boardout),
		.o_spi_mode     (o_spi_mode),
		.o_spi_reset_n  (o_spi_reset_n),
		.o_miso_sel     (o_miso_sel),
		.i_acqstate     (i_acqstate),
		.i_eventcounter (i_eventcounter),
		.i_boardin      (i_boardin)
	);

	resp_tx u_tx (
		.clk      (clk),
		.rstn     (rstn),
		.i_load   (resp_load),
		.i_word   (resp),
		.o_free   (resp_free),
		.o_tvalid (o_tvalid),
		.o_tdata  (o_tdata),
		.o_tkeep  (o_tkeep),
		.o_tlast  (o_tlast),
		.i_tready (i_out_ready)
	);

endmodule

/* source/spi_sequencer.sv */
`timescale 1ns/1ps
`include "scope_ctl_defs.svh"

module spi_sequencer (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_start,
	input  periph_pkg::spi_req_t i_req,
	output logic                 o_done,
	output cmd_pkg::byte_t       o_rd_hi,
	output cmd_pkg::byte_t       o_rd_lo,
	output cmd_pkg::byte_t       o_spi_tx,
	output logic                 o_spi_txdv,
	input  logic                 i_spi_txready,
	input  logic                 i_spi_rxdv,
	input  cmd_pkg::byte_t       i_spi_rx,
	output logic [7:0]           o_spi_cs
);

	periph_pkg::spi_state_e state;
	periph_pkg::spi_req_t   req_q;
	logic [1:0]             idx;      // byte being transferred
	logic [5:0]             wait_cnt; // setup and hold timer
	logic                   last_byte;

	assign last_byte = (idx == req_q.cnt_code);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= periph_pkg::SPI_IDLE;
			idx        <= '0;
			wait_cnt   <= '0;
			o_spi_txdv <= 1'b0;
			o_spi_cs   <= '1;
			o_done     <= 1'b0;
		end else begin
			o_spi_txdv <= 1'b0;
			o_done     <= 1'b0;
			case (state)
				periph_pkg::SPI_IDLE: begin
					if (i_start) begin
						o_spi_cs <= ~(8'd1 << i_req.chip); // one select low
						idx      <= '0;
						wait_cnt <= '0;
						state    <= periph_pkg::SPI_SETUP;
					end
				end
				periph_pkg::SPI_SETUP: begin
					if (wait_cnt == 6'(`SPI_CS_SETUP - 1)) begin
						wait_cnt <= '0;
						state    <= periph_pkg::SPI_SEND;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				periph_pkg::SPI_SEND: begin
					if (i_spi_txready) begin
						o_spi_txdv <= 1'b1;
						state      <= periph_pkg::SPI_WAIT;
					end
				end
				periph_pkg::SPI_WAIT: begin
					if (i_spi_rxdv) begin
						if (last_byte) begin
							state <= periph_pkg::SPI_HOLD;
						end else begin
							idx   <= idx + 2'd1;
							state <= periph_pkg::SPI_SEND;
						end
					end
				end
				periph_pkg::SPI_HOLD: begin
					if (wait_cnt == 6'(`SPI_CS_HOLD - 1)) begin
						wait_cnt <= '0;
						o_spi_cs <= '1;
						o_done   <= 1'b1;
						state    <= periph_pkg::SPI_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				default: state <= periph_pkg::SPI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == periph_pkg::SPI_IDLE && i_start) req_q <= i_req;
		if (state == periph_pkg::SPI_SEND && i_spi_txready) o_spi_tx <= req_q.tx[idx];
		if (state == periph_pkg::SPI_WAIT && i_spi_rxdv) begin
			if (idx == 2'd0) o_rd_hi <= i_spi_rx; // slow adc reply comes here
			if (last_byte) o_rd_lo <= i_spi_rx;
		end
	end

endmodule

/* test/scope_ctl_tb.sv */
`timescale 1ns/1ps
`include "scope_ctl_defs.svh"

module scope_ctl_tb;

	localparam int CYCLE_LIMIT = 20000; // tests need about 1500 cycles

	logic                  clk = 1'b0;
	logic                  rstn;
	logic                  i_tvalid;
	cmd_pkg::byte_t        i_tdata;
	logic                  o_in_ready;
	logic                  i_out_ready;
	logic                  o_tvalid;
	cmd_pkg::resp_word_t   o_tdata;
	logic [3:0]            o_tkeep;
	logic                  o_tlast;
	cmd_pkg::byte_t        o_spi_tx;
	logic                  o_spi_txdv;
	logic                  i_spi_txready;
	logic                  i_spi_rxdv;
	cmd_pkg::byte_t        i_spi_rx;
	logic [7:0]            o_spi_cs;
	logic [2:0]            o_miso_sel;
	logic [1:0]            o_spi_mode;
	logic                  o_spi_reset_n;
	periph_pkg::trig_cfg_t o_trig;
	periph_pkg::acq_cfg_t  o_acq;
	logic [7:0]            o_boardout;
	logic [7:0]            i_acqstate;
	logic [31:0]           i_eventcounter;
	logic [7:0]            i_boardin;

	int                    errors = 0;
	int                    checks = 0;
	int                    resp_total = 0; // accepted response beats
	int                    known_sent = 0;
	int                    tx_pulses = 0;
	int                    rst_lows = 0;
	int                    cycles = 0;
	int                    rx_wait = 0;
	logic                  rx_fire;
	cmd_pkg::byte_t        sent_byte = '0;
	cmd_pkg::byte_t        tx_exp[4]; // bytes the spi engine should send, in order
	logic [7:0]            exp_cs;   // select expected low during spi
	cmd_pkg::resp_word_t   rq[$];    // responses seen on the output stream

	always #4 clk = ~clk;

	scope_ctl_top dut (
		.clk            (clk),
		.rstn           (rstn),
		.i_tvalid       (i_tvalid),
		.i_tdata        (i_tdata),
		.o_in_ready     (o_in_ready),
		.i_out_ready    (i_out_ready),
		.o_tvalid       (o_tvalid),
		.o_tdata        (o_tdata),
		.o_tkeep        (o_tkeep),
		.o_tlast        (o_tlast),
		.o_spi_tx       (o_spi_tx),
		.o_spi_txdv     (o_spi_txdv),
		.i_spi_txready  (i_spi_txready),
		.i_spi_rxdv     (i_spi_rxdv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_cs       (o_spi_cs),
		.o_miso_sel     (o_miso_sel),
		.o_spi_mode     (o_spi_mode),
		.o_spi_reset_n  (o_spi_reset_n),
		.o_trig         (o_trig),
		.o_acq          (o_acq),
		.o_boardout     (o_boardout),
		.i_acqstate     (i_acqstate),
		.i_eventcounter (i_eventcounter),
		.i_boardin      (i_boardin)
	);

	hold_stable: assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_out_ready) |=> (o_tvalid && $stable(o_tdata)))
	else begin
		errors++;
		$display("FAIL %0t: response word changed or dropped while stalled", $time);
	end

	beat_flags: assert property (@(posedge clk) disable iff (!rstn)
		o_tvalid |-> (o_tkeep == 4'hf && o_tlast))
	else begin
		errors++;
		$display("FAIL %0t: tkeep %h tlast %b on a valid beat", $time, o_tkeep, o_tlast);
	end

	cs_select: assert property (@(posedge clk) disable iff (!rstn)
		(o_spi_cs == 8'hff) || (o_spi_cs == exp_cs))
	else begin
		errors++;
		$display("FAIL %0t: chip select %h, expected ff or %h", $time, o_spi_cs, exp_cs);
	end

	cs_on_tx: assert property (@(posedge clk) disable iff (!rstn)
		o_spi_txdv |-> (o_spi_cs == exp_cs))
	else begin
		errors++;
		$display("FAIL %0t: byte sent with chip select %h", $time, o_spi_cs);
	end

	// host side of the response stream, random stalls
	always @(posedge clk) begin
		if (rstn && o_tvalid && i_out_ready) begin
			rq.push_back(o_tdata);
			resp_total++;
		end
		#1;
		i_out_ready = ($urandom % 4) != 0;
	end

	// spi peripheral, answers ~tx three cycles after each txdv
	always @(posedge clk) begin
		rx_fire = 1'b0;
		if (rx_wait != 0) begin
			rx_wait = rx_wait - 1;
			rx_fire = (rx_wait == 0);
		end
		if (o_spi_txdv) begin
			assert (tx_pulses < 4 && o_spi_tx == tx_exp[tx_pulses]) else begin
				errors++;
				$display("FAIL %0t: spi byte %0d is %h", $time, tx_pulses, o_spi_tx);
			end
			tx_pulses++;
			sent_byte = o_spi_tx;
			rx_wait = 2;
		end
		if (rstn && !o_spi_reset_n) rst_lows++;
		#1;
		i_spi_rxdv = rx_fire;
		i_spi_rx   = ~sent_byte;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic bit is_known(input cmd_pkg::byte_t op);
		return op inside {8'd3, 8'd4, 8'd8, 8'd9, 8'd10, 8'd14};
	endfunction

	// ((a1 -/+ a2 - center) * 16) + round, cut to 12 bits
	function automatic logic [11:0] thresh(input int a1, input int a2, input bit upper);
		int v;
		v = ((upper ? a1 + a2 : a1 - a2) - `THRESH_CENTER) * 16 + `THRESH_ROUND;
		return v[11:0];
	endfunction

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic send_cmd(input cmd_pkg::byte_t op, a1, a2, a3, a4, a5, a7);
		cmd_pkg::cmd_frame_t f;
		f = {op, a1, a2, a3, a4, a5, 8'($urandom), a7};
		for (int i = 7; i >= 0; i--) begin
			i_tvalid = 1'b1;
			i_tdata  = f[i*8 +: 8];
			@(posedge clk);
			while (!o_in_ready) @(posedge clk);
			#1;
		end
		i_tvalid = 1'b0;
		if (is_known(op)) known_sent++;
	endtask

	task automatic expect_resp(input cmd_pkg::resp_word_t exp, input string what);
		cmd_pkg::resp_word_t got;
		while (rq.size() == 0) begin
			@(posedge clk);
			#1;
		end
		got = rq.pop_front();
		check_val(64'(got), 64'(exp), what);
	endtask

	initial begin
		cmd_pkg::byte_t      a1;
		cmd_pkg::byte_t      a2;
		cmd_pkg::byte_t      a3;
		cmd_pkg::byte_t      a4;
		cmd_pkg::byte_t      a5;
		cmd_pkg::byte_t      code;
		cmd_pkg::byte_t      last;
		logic [11:0]         lo;
		logic [11:0]         hi;
		logic [7:0]          board_m;
		int                  nbytes;
		cmd_pkg::resp_word_t exp_q[$];

		void'($urandom(32'h548d_aa05));
		rstn           = 1'b0;
		i_tvalid       = 1'b0;
		i_tdata        = '0;
		i_out_ready    = 1'b0;
		i_spi_txready  = 1'b1;
		i_spi_rxdv     = 1'b0;
		i_spi_rx       = '0;
		i_acqstate     = 8'($urandom);
		i_eventcounter = $urandom;
		i_boardin      = 8'($urandom);
		exp_cs         = 8'hff;
		board_m        = '0;
		repeat (4) @(posedge clk);
		#1 rstn = 1'b1;
		@(posedge clk);
		#1;

		// trigger thresholds
		repeat (4) begin
			a1 = 8'($urandom);
			a2 = 8'($urandom);
			a3 = 8'($urandom);
			a4 = 8'($urandom);
			lo = thresh(int'(a1), int'(a2), 1'b0);
			hi = thresh(int'(a1), int'(a2), 1'b1);
			send_cmd(8'd8, a1, a2, a3, a4, 8'd0, 8'd0);
			expect_resp(32'd8, "trigger set response");
			check_val(64'(o_trig), 64'({lo, hi, a3, a4[0]}), "trigger settings");
			send_cmd(8'd14, 8'd6, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
			expect_resp({20'd0, hi}, "read upper threshold");
		end

		// acquisition settings and read back
		a1 = 8'($urandom);
		a2 = 8'($urandom);
		a3 = 8'($urandom);
		send_cmd(8'd9, a1, a2, a3, 8'd0, 8'd0, 8'd0);
		expect_resp(32'd9, "acq set response");
		check_val(64'(o_acq), 64'({a1[4:0], a2[0], a3}), "acq settings");
		send_cmd(8'd14, 8'd4, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp({27'd0, a1[4:0]}, "read downsample");
		send_cmd(8'd14, 8'd5, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp({31'd0, a2[0]}, "read highres");
		send_cmd(8'd14, 8'd7, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp({24'd0, a3}, "read merging");
		send_cmd(8'd14, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp(32'(`SCOPE_VERSION), "read version");
		send_cmd(8'd14, 8'd1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp({24'd0, i_boardin}, "read boardin");
		send_cmd(8'd14, 8'd2, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp({24'd0, i_acqstate}, "read acqstate");
		send_cmd(8'd14, 8'd3, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp(i_eventcounter, "read eventcounter");
		send_cmd(8'd14, 8'd20, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		expect_resp(32'd0, "read unmapped register");

		// board output bits, reply is the old value
		repeat (8) begin
			a1 = 8'($urandom);
			a2 = 8'($urandom);
			send_cmd(8'd10, a1, a2, 8'd0, 8'd0, 8'd0, 8'd0);
			expect_resp({24'd0, board_m}, "board out response");
			board_m[a1[2:0]] = a2[0];
			check_val(64'(o_boardout), 64'(board_m), "board outputs");
		end

		// spi transfers of 2, 3, 4 bytes and an odd count code
		for (int c = 0; c < 4; c++) begin
			code   = (c == 3) ? 8'd7 : 8'(c + 2);
			nbytes = (code == 8'd2) ? 2 : (code == 8'd4) ? 4 : 3;
			a1 = 8'($urandom);
			a2 = 8'($urandom);
			a3 = 8'($urandom);
			a4 = 8'($urandom);
			a5 = 8'($urandom);
			last = (nbytes == 2) ? a3 : (nbytes == 4) ? a5 : a4;
			tx_exp[0] = a2;
			tx_exp[1] = a3;
			tx_exp[2] = a4;
			tx_exp[3] = a5;
			exp_cs = ~(8'd1 << a1[2:0]);
			tx_pulses = 0;
			send_cmd(8'd3, a1, a2, a3, a4, a5, code);
			expect_resp({16'd0, ~a2, ~last}, "spi read bytes");
			check_val(64'(tx_pulses), 64'(nbytes), "spi txdv pulses");
			check_val(64'(o_miso_sel), 64'(a1[2:0]), "miso select");
			check_val(64'(o_spi_cs), 64'(8'hff), "chip selects after transfer");
			exp_cs = 8'hff;
		end

		// spi mode with engine reset
		repeat (2) begin
			a1 = 8'($urandom);
			rst_lows = 0;
			send_cmd(8'd4, a1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
			expect_resp({24'd0, a1}, "spi mode response");
			check_val(64'(o_spi_mode), 64'(a1[1:0]), "spi mode");
			check_val(64'(rst_lows), 64'd1, "spi reset low cycles");
		end

		// back to back reads mixed with unknown opcodes
		for (int i = 0; i < 6; i++) begin
			a1 = (i % 3 == 0) ? 8'd0 : (i % 3 == 1) ? 8'd20 : 8'd2;
			exp_q.push_back((i % 3 == 0) ? 32'(`SCOPE_VERSION) :
				(i % 3 == 1) ? 32'd0 : {24'd0, i_acqstate});
			send_cmd(8'd14, a1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
			send_cmd((i % 3 == 0) ? 8'd0 : (i % 3 == 1) ? 8'd12 : 8'hff,
				8'($urandom), 8'd0, 8'd0, 8'd0, 8'd0, 8'd0);
		end
		while (exp_q.size() != 0) expect_resp(exp_q.pop_front(), "burst read");

		repeat (20) @(posedge clk);
		#1;
		check_val(64'(resp_total), 64'(known_sent), "response count");

		$display("checks %0d, errors %0d, responses %0d for %0d known commands",
			checks, errors, resp_total, known_sent);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
